//--- Makefile
TOP := tb_lb_slave

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 -Wno-fatal -f sim.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "=== PASS ==="

lint:
	verilator --lint-only --timing -Wall -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- lb_bus_if.sv
`timescale 1ns/10ps

interface lb_bus_if;

	import lb_pkg::*;

	// Request from the host master
	lb_addr_u addr;
	logic     strobe;
	// High for a read, low for a write
	logic     rd;
	lb_word_t wdata;

	// Bus master side
	modport host (
		output addr,
		output strobe,
		output rd,
		output wdata
	);

	// Register block side
	modport device (
		input addr,
		input strobe,
		input rd,
		input wdata
	);

endinterface

//--- lb_ctrl_regs.sv
`timescale 1ns/10ps
`include "lb_defines.svh"

module lb_ctrl_regs (
	input  logic             clk,
	input  logic             arst_n,
	lb_bus_if.device         bus,
	output lb_pkg::lb_word_t mirror_word,
	output logic             rx_mac_hbank,
	output logic             led_user_mode,
	output logic             led1,
	output logic             led2,
	output logic [7:0]       misc_config
);

	import lb_pkg::*;

	localparam int mirror_depth = 1 << `LB_MIRROR_AW;

	logic                   local_write;
	logic [`LB_INDEX_W-1:0] reg_index;
	logic [`LB_DUTY_W-1:0]  led1_df;
	logic [`LB_DUTY_W-1:0]  led2_df;
	logic [`LB_LED_CW-1:0]  led_cc;

	lb_word_t mirror_mem [0:mirror_depth-1];

	assign reg_index = bus.addr.reg_view.index;

	// Direct write to the local page
	assign local_write = bus.strobe & ~bus.rd &
		(bus.addr.reg_view.page == `LB_PAGE_LOCAL);

	// Configuration registers
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			led_user_mode <= 1'b0;
			led1_df       <= '0;
			led2_df       <= '0;
			rx_mac_hbank  <= `LB_HBANK_DEFAULT;
			misc_config   <= `LB_MISC_DEFAULT;
		end else if (local_write) begin
			case (reg_index)
				`LB_REG_LED_USER: led_user_mode <= bus.wdata[0];
				`LB_REG_LED1:     led1_df       <= bus.wdata[`LB_DUTY_W-1:0];
				`LB_REG_LED2:     led2_df       <= bus.wdata[`LB_DUTY_W-1:0];
				`LB_REG_HBANK:    rx_mac_hbank  <= bus.wdata[0];
				`LB_REG_MISC:     misc_config   <= bus.wdata[7:0];
				default: ;
			endcase
		end
	end

	// Every local write lands in the mirror, whatever the index
	always_ff @(posedge clk) begin
		if (local_write) begin
			mirror_mem[reg_index[`LB_MIRROR_AW-1:0]] <= bus.wdata;
		end
	end

	// Mirror is read each cycle at the current address
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mirror_word <= '0;
		end else begin
			mirror_word <= mirror_mem[reg_index[`LB_MIRROR_AW-1:0]];
		end
	end

	// Free-running PWM counter, period of 1024 cycles
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			led_cc <= '0;
		end else begin
			led_cc <= led_cc + 1'b1;
		end
	end

	// LED is on while the count is below four times the duty factor
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			led1 <= 1'b0;
			led2 <= 1'b0;
		end else begin
			led1 <= led_cc < {led1_df, 2'b00};
			led2 <= led_cc < {led2_df, 2'b00};
		end
	end

endmodule

//--- lb_defines.svh
`ifndef LB_DEFINES_SVH
`define LB_DEFINES_SVH

// Bus field widths
`define LB_ADDR_W        24
`define LB_DATA_W        32
`define LB_PAGE_W        8
`define LB_OFFSET_W      16
`define LB_INDEX_W       5

// Address pages
`define LB_PAGE_STATUS   8'h00
`define LB_PAGE_LOCAL    8'h05

// Register indices within the local page
`define LB_REG_LED_USER  5'd1
`define LB_REG_LED1      5'd2
`define LB_REG_LED2      5'd3
`define LB_REG_HBANK     5'd5
`define LB_REG_MISC      5'd8

// Mirror memory holds 32 words
`define LB_MIRROR_AW     5

// LED counter and uptime prescaler
`define LB_LED_CW        10
`define LB_DUTY_W        8

// Reset and fill values
`define LB_MISC_DEFAULT  8'h00
`define LB_HBANK_DEFAULT 1'b1
`define LB_UNMAPPED      32'hdeadbeef
`define LB_BANK_DEFAULT  "zzzz"

`endif

//--- lb_pkg.sv
`include "lb_defines.svh"

package lb_pkg;

	// Address page, the top byte of the bus address
	typedef logic [`LB_PAGE_W-1:0] lb_page_t;

	// One bus data word
	typedef logic [`LB_DATA_W-1:0] lb_word_t;

	// Page and offset, as seen by the read path
	typedef struct packed {
		lb_page_t                page;
		logic [`LB_OFFSET_W-1:0] offset;
	} lb_page_view_t;

	// Page and register index, as seen by the write decoder
	typedef struct packed {
		lb_page_t                                         page;
		logic [`LB_ADDR_W-`LB_PAGE_W-`LB_INDEX_W-1:0]     spare;
		logic [`LB_INDEX_W-1:0]                           index;
	} lb_reg_view_t;

	// Both views cover the same 24-bit address
	typedef union packed {
		lb_page_view_t page_view;
		lb_reg_view_t  reg_view;
	} lb_addr_u;

endpackage

//--- lb_read_mux.sv
`timescale 1ns/10ps
`include "lb_defines.svh"

module lb_read_mux (
	input  logic             clk,
	input  logic             arst_n,
	input  lb_pkg::lb_addr_u addr,
	input  logic             rd_strobe,
	input  lb_pkg::lb_word_t bank_word,
	input  lb_pkg::lb_word_t mirror_word,
	output lb_pkg::lb_word_t data_in
);

	import lb_pkg::*;

	lb_page_t page_r;
	logic     rd_r;

	// Page of the read in flight, captured alongside its valid bit
	always_ff @(posedge clk) begin
		page_r <= addr.page_view.page;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_r <= 1'b0;
		end else begin
			rd_r <= rd_strobe;
		end
	end

	// Second read cycle, the sources have registered their words by now
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			data_in <= '0;
		end else if (rd_r) begin
			case (page_r)
				`LB_PAGE_STATUS: data_in <= bank_word;
				`LB_PAGE_LOCAL:  data_in <= mirror_word;
				default:         data_in <= `LB_UNMAPPED;
			endcase
		end
	end

endmodule

//--- lb_slave_top.sv
`timescale 1ns/10ps

module lb_slave_top (
	input  logic             clk,
	input  logic             arst_n,
	input  lb_pkg::lb_addr_u addr,
	input  logic             strobe,
	input  logic             rd,
	input  lb_pkg::lb_word_t wdata,
	output lb_pkg::lb_word_t data_in,
	input  logic             xdomain_fault,
	input  logic             tx_mac_done,
	input  logic [1:0]       rx_mac_buf_status,
	output logic             rx_mac_hbank,
	output logic             led_user_mode,
	output logic             led1,
	output logic             led2,
	output logic [7:0]       misc_config
);

	import lb_pkg::*;

	lb_word_t bank_word;
	lb_word_t mirror_word;
	logic     rd_strobe;

	lb_bus_if bus ();

	// Host side of the local bus
	assign bus.addr   = addr;
	assign bus.strobe = strobe;
	assign bus.rd     = rd;
	assign bus.wdata  = wdata;

	assign rd_strobe = strobe & rd;

	lb_ctrl_regs u_lb_ctrl_regs (
		.clk           (clk),
		.arst_n        (arst_n),
		.bus           (bus.device),
		.mirror_word   (mirror_word),
		.rx_mac_hbank  (rx_mac_hbank),
		.led_user_mode (led_user_mode),
		.led1          (led1),
		.led2          (led2),
		.misc_config   (misc_config)
	);

	lb_status_regs u_lb_status_regs (
		.clk               (clk),
		.arst_n            (arst_n),
		.bus               (bus.device),
		.xdomain_fault     (xdomain_fault),
		.tx_mac_done       (tx_mac_done),
		.rx_mac_buf_status (rx_mac_buf_status),
		.bank_word         (bank_word)
	);

	lb_read_mux u_lb_read_mux (
		.clk         (clk),
		.arst_n      (arst_n),
		.addr        (addr),
		.rd_strobe   (rd_strobe),
		.bank_word   (bank_word),
		.mirror_word (mirror_word),
		.data_in     (data_in)
	);

endmodule

//--- lb_status_regs.sv
`timescale 1ns/10ps
`include "lb_defines.svh"

module lb_status_regs (
	input  logic             clk,
	input  logic             arst_n,
	lb_bus_if.device         bus,
	input  logic             xdomain_fault,
	input  logic             tx_mac_done,
	input  logic [1:0]       rx_mac_buf_status,
	output lb_pkg::lb_word_t bank_word
);

	import lb_pkg::*;

	// Identification words at offsets 0 to 3
	localparam lb_word_t id_word_0 = "Hell";
	localparam lb_word_t id_word_1 = "o wo";
	localparam lb_word_t id_word_2 = "rld!";
	localparam lb_word_t id_word_3 = "(::)";

	logic                  do_rd;
	logic [3:0]            bank_sel;
	logic [15:0]           fault_count;
	logic [`LB_LED_CW-1:0] prescale;
	logic [31:0]           uptime;
	logic                  tx_mac_done_r;
	logic [1:0]            rx_mac_buf_status_r;

	assign do_rd    = bus.strobe & bus.rd;
	assign bank_sel = bus.addr.page_view.offset[3:0];

	// Counts cycles with a clock-crossing fault, wraps silently
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			fault_count <= '0;
		end else if (xdomain_fault) begin
			fault_count <= fault_count + 1'b1;
		end
	end

	// Uptime ticks once per prescaler wrap
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			prescale <= '0;
			uptime   <= '0;
		end else begin
			prescale <= prescale + 1'b1;
			if (&prescale) begin
				uptime <= uptime + 1'b1;
			end
		end
	end

	// MAC status is brought into clk before it is read
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			tx_mac_done_r       <= 1'b0;
			rx_mac_buf_status_r <= '0;
		end else begin
			tx_mac_done_r       <= tx_mac_done;
			rx_mac_buf_status_r <= rx_mac_buf_status;
		end
	end

	// First read cycle, bank word selected by the low offset bits
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bank_word <= '0;
		end else if (do_rd) begin
			case (bank_sel)
				4'h0:    bank_word <= id_word_0;
				4'h1:    bank_word <= id_word_1;
				4'h2:    bank_word <= id_word_2;
				4'h3:    bank_word <= id_word_3;
				4'h4:    bank_word <= {16'h0000, fault_count};
				4'h6:    bank_word <= {31'h0, tx_mac_done_r};
				4'h7:    bank_word <= {30'h0, rx_mac_buf_status_r};
				4'h8:    bank_word <= uptime;
				default: bank_word <= `LB_BANK_DEFAULT;
			endcase
		end
	end

endmodule

//--- sim.f
+incdir+.
lb_pkg.sv
lb_bus_if.sv
lb_ctrl_regs.sv
lb_status_regs.sv
lb_read_mux.sv
lb_slave_top.sv
tb_lb_slave.sv

//--- tb_lb_slave.sv
`timescale 1ns/10ps
`include "lb_defines.svh"

module tb_lb_slave;

	import lb_pkg::*;

	localparam int cycle_limit = 40000;
	localparam logic [31:0] lfsr_seed = 32'hd2458be2;
	// x^32 + x^22 + x^2 + x + 1, right-shifting form
	localparam logic [31:0] lfsr_taps = 32'h80200003;

	logic       clk = 1'b0;
	logic       arst_n;
	lb_addr_u   addr;
	logic       strobe;
	logic       rd;
	lb_word_t   wdata;
	lb_word_t   data_in;
	logic       xdomain_fault;
	logic       tx_mac_done;
	logic [1:0] rx_mac_buf_status;
	logic       rx_mac_hbank;
	logic       led_user_mode;
	logic       led1;
	logic       led2;
	logic [7:0] misc_config;

	logic [31:0] lfsr_state;
	int          cycle_count;
	int          word_errors = 0;
	int          bit_errors = 0;
	int          byte_errors = 0;

	// Reads in flight, bit 1 is due this cycle
	logic [1:0]  rd_pipe;
	lb_word_t    exp_reads [$];
	// Last word written to each local index
	lb_word_t    reg_model [int];

	lb_slave_top u_lb_slave_top (
		.clk               (clk),
		.arst_n            (arst_n),
		.addr              (addr),
		.strobe            (strobe),
		.rd                (rd),
		.wdata             (wdata),
		.data_in           (data_in),
		.xdomain_fault     (xdomain_fault),
		.tx_mac_done       (tx_mac_done),
		.rx_mac_buf_status (rx_mac_buf_status),
		.rx_mac_hbank      (rx_mac_hbank),
		.led_user_mode     (led_user_mode),
		.led1              (led1),
		.led2              (led2),
		.misc_config       (misc_config)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ lfsr_taps;
		end
		return n;
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		return r;
	endfunction

	function automatic lb_addr_u local_addr(logic [4:0] index);
		lb_addr_u    a;
		logic [31:0] r;
		r = rand_bits(11);
		a.reg_view.page  = `LB_PAGE_LOCAL;
		a.reg_view.spare = r[10:0];
		a.reg_view.index = index;
		return a;
	endfunction

	// Upper offset bits are ignored by the bank select
	function automatic lb_addr_u status_addr(logic [3:0] sel);
		lb_addr_u    a;
		logic [31:0] r;
		r = rand_bits(12);
		a.page_view.page   = `LB_PAGE_STATUS;
		a.page_view.offset = {r[11:0], sel};
		return a;
	endfunction

	function automatic lb_addr_u unmapped_addr();
		lb_addr_u    a;
		logic [31:0] r;
		r = rand_bits(24);
		while (r[23:16] == `LB_PAGE_STATUS || r[23:16] == `LB_PAGE_LOCAL) begin
			r = rand_bits(24);
		end
		a = r[23:0];
		return a;
	endfunction

	function automatic lb_word_t model_reg(int index, lb_word_t reset_value);
		if (reg_model.exists(index)) begin
			return reg_model[index];
		end
		return reset_value;
	endfunction

	task automatic check_word(string name, lb_word_t expected, lb_word_t actual);
		if (actual !== expected) begin
			word_errors++;
			$display("Fail %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic check_bit(string name, logic expected, logic actual);
		if (actual !== expected) begin
			bit_errors++;
			$display("Fail %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic check_byte(string name, logic [7:0] expected, logic [7:0] actual);
		if (actual !== expected) begin
			byte_errors++;
			$display("Fail %s expected %h actual %h", name, expected, actual);
		end
	endtask

	// Advance to the drive point and retire the read issued two cycles ago
	task automatic next_cycle();
		lb_word_t expected;
		@(posedge clk);
		#1;
		if (rd_pipe[1]) begin
			if (exp_reads.size() == 0) begin
				word_errors++;
				$display("A read completed with no expected value queued");
			end else begin
				expected = exp_reads.pop_front();
				check_word("data_in", expected, data_in);
			end
		end
		rd_pipe = {rd_pipe[0], 1'b0};
	endtask

	task automatic bus_write(lb_addr_u a, lb_word_t d);
		addr   = a;
		wdata  = d;
		rd     = 1'b0;
		strobe = 1'b1;
		if (a.reg_view.page == `LB_PAGE_LOCAL) begin
			reg_model[int'(a.reg_view.index)] = d;
		end
		next_cycle();
		strobe = 1'b0;
	endtask

	task automatic bus_read(lb_addr_u a, lb_word_t expected);
		addr   = a;
		rd     = 1'b1;
		strobe = 1'b1;
		exp_reads.push_back(expected);
		rd_pipe[0] = 1'b1;
		next_cycle();
		strobe = 1'b0;
		rd     = 1'b0;
	endtask

	// Only used with no other read in flight
	task automatic read_now(lb_addr_u a, output lb_word_t value);
		addr   = a;
		rd     = 1'b1;
		strobe = 1'b1;
		next_cycle();
		strobe = 1'b0;
		rd     = 1'b0;
		next_cycle();
		value = data_in;
	endtask

	initial begin
		cycle_count = 0;
		while (cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		lb_word_t    value;
		lb_word_t    first;
		lb_word_t    delta;
		lb_word_t    base;
		lb_word_t    expected;
		lb_word_t    fault_total;
		lb_word_t    high1;
		lb_word_t    high2;
		logic [31:0] r;
		logic [31:0] upper;
		logic [4:0]  idx;
		int          span;
		int          k;

		lfsr_state        = lfsr_seed;
		rd_pipe           = '0;
		arst_n            = 1'b0;
		addr              = '0;
		strobe            = 1'b0;
		rd                = 1'b0;
		wdata             = '0;
		xdomain_fault     = 1'b0;
		tx_mac_done       = 1'b0;
		rx_mac_buf_status = 2'b00;
		repeat (16) @(posedge clk);
		#1;
		arst_n = 1'b1;

		check_bit("led1", 1'b0, led1);
		check_bit("led2", 1'b0, led2);
		check_bit("led_user_mode", 1'b0, led_user_mode);
		check_bit("rx_mac_hbank", `LB_HBANK_DEFAULT, rx_mac_hbank);
		check_byte("misc_config", `LB_MISC_DEFAULT, misc_config);
		check_word("data_in", '0, data_in);

		// Mirror fill then back-to-back readback
		for (int i = 0; i < 200; i++) begin
			r = rand_bits(5);
			bus_write(local_addr(r[4:0]), rand_bits(32));
		end
		for (int i = 0; i < 32; i++) begin
			if (reg_model.exists(i)) begin
				bus_read(local_addr(i[4:0]), reg_model[i]);
			end
		end
		next_cycle();
		next_cycle();

		for (int i = 0; i < 24; i++) begin
			r = rand_bits(2);
			case (r[1:0])
				2'd0:    idx = `LB_REG_LED_USER;
				2'd1:    idx = `LB_REG_HBANK;
				default: idx = `LB_REG_MISC;
			endcase
			bus_write(local_addr(idx), rand_bits(32));
		end
		next_cycle();
		value = model_reg(int'(`LB_REG_LED_USER), 32'h0);
		check_bit("led_user_mode", value[0], led_user_mode);
		value = model_reg(int'(`LB_REG_HBANK), {31'h0, `LB_HBANK_DEFAULT});
		check_bit("rx_mac_hbank", value[0], rx_mac_hbank);
		value = model_reg(int'(`LB_REG_MISC), {24'h0, `LB_MISC_DEFAULT});
		check_byte("misc_config", value[7:0], misc_config);

		// Identification words, unused offsets, unmapped pages
		bus_read(status_addr(4'h0), "Hell");
		bus_read(status_addr(4'h1), "o wo");
		bus_read(status_addr(4'h2), "rld!");
		bus_read(status_addr(4'h3), "(::)");
		for (int i = 9; i < 16; i++) begin
			bus_read(status_addr(i[3:0]), "zzzz");
		end
		for (int i = 0; i < 16; i++) begin
			bus_read(unmapped_addr(), 32'hdeadbeef);
		end
		next_cycle();
		next_cycle();

		fault_total = '0;
		r = rand_bits(7);
		span = 64 + int'(r[6:0]);
		for (int i = 0; i < span; i++) begin
			r = rand_bits(1);
			xdomain_fault = r[0];
			fault_total = fault_total + {31'h0, r[0]};
			next_cycle();
		end
		xdomain_fault = 1'b0;
		bus_read(status_addr(4'h4), fault_total);

		for (int i = 0; i < 4; i++) begin
			r = rand_bits(3);
			tx_mac_done = r[0];
			rx_mac_buf_status = r[2:1];
			next_cycle();
			next_cycle();
			bus_read(status_addr(4'h6), {31'h0, r[0]});
			bus_read(status_addr(4'h7), {30'h0, r[2:1]});
		end
		next_cycle();
		next_cycle();

		// PWM duty over one full counter period
		for (int t = 0; t < 3; t++) begin
			r = rand_bits(16);
			upper = rand_bits(24);
			bus_write(local_addr(`LB_REG_LED1), {upper[23:0], r[7:0]});
			bus_write(local_addr(`LB_REG_LED2), {upper[23:0], r[15:8]});
			next_cycle();
			next_cycle();
			high1 = '0;
			high2 = '0;
			for (int c = 0; c < 1024; c++) begin
				high1 = high1 + {31'h0, led1};
				high2 = high2 + {31'h0, led2};
				next_cycle();
			end
			check_word("led1_high_cycles", {22'h0, r[7:0], 2'b00}, high1);
			check_word("led2_high_cycles", {22'h0, r[15:8], 2'b00}, high2);
		end

		// Two uptime samples K cycles apart
		read_now(status_addr(4'h8), first);
		r = rand_bits(12);
		k = 1500 + int'(r[11:0]);
		repeat (k - 2) next_cycle();
		read_now(status_addr(4'h8), value);
		delta = value - first;
		base = k / 1024;
		expected = (delta == base + 1) ? base + 1 : base;
		check_word("uptime_delta", expected, delta);

		$display("Errors: word %0d, bit %0d, byte %0d", word_errors, bit_errors, byte_errors);
		if (word_errors + bit_errors + byte_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule
